//--- branch_resolve.sv
/* redirect decisions: jal in D, jalr and conditional branches in X
   the caller gates each redirect with its own stage stall */
`timescale 1ns/1ps

module branch_resolve import proc_ctrl_pkg::*; (
  input  logic     val_d_i,
  input  br_type_e br_d_i,
  input  logic     val_x_i,
  input  br_type_e br_x_i,
  input  br_cond_t cond_i,
  output logic     redirect_d_o,
  output logic     redirect_x_o,
  output pc_sel_e  pc_sel_o
);

  assign redirect_d_o = val_d_i && (br_d_i == BR_JAL);

  // taken test per branch type
  always_comb begin
    case (br_x_i)
      BR_JALR: redirect_x_o = val_x_i;
      BR_BEQ:  redirect_x_o = val_x_i && cond_i.eq;
      BR_BNE:  redirect_x_o = val_x_i && !cond_i.eq;
      BR_BLT:  redirect_x_o = val_x_i && cond_i.lt;
      BR_BGE:  redirect_x_o = val_x_i && !cond_i.lt;
      BR_BLTU: redirect_x_o = val_x_i && cond_i.ltu;
      BR_BGEU: redirect_x_o = val_x_i && !cond_i.ltu;
      default: redirect_x_o = 1'b0;
    endcase
  end

  // older instruction in X has priority
  always_comb begin
    if (redirect_x_o)
      pc_sel_o = (br_x_i == BR_JALR) ? PC_JALR : PC_BRANCH;
    else if (redirect_d_o)
      pc_sel_o = PC_JAL;
    else
      pc_sel_o = PC_PLUS4;
  end

endmodule

//--- ctrl_stage_reg.sv
/* pipeline register for one stage: valid bit plus control payload
   payload has no reset, only valid is cleared */
`timescale 1ns/1ps

module ctrl_stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     en_i,
  input  logic     val_i,
  input  payload_t pay_i,
  output logic     val_o,
  output payload_t pay_o
);

  always_ff @(posedge clk) begin
    if (reset)
      val_o <= 1'b0;
    else if (en_i)
      val_o <= val_i;
  end

  // hold payload while stalled
  always_ff @(posedge clk) begin
    if (en_i)
      pay_o <= pay_i;
  end

endmodule

//--- hazard_unit.sv
/* load-use detection and bypass select for the D operands
   x0 never matches; a load in X stalls instead of bypassing */
`timescale 1ns/1ps

module hazard_unit import proc_ctrl_pkg::*; (
  input  logic      clk,
  input  dec_ctrl_t dec_i,
  input  logic      val_d_i,
  input  logic      val_x_i,
  input  x_ctrl_t   x_i,
  input  logic      val_m_i,
  input  m_ctrl_t   m_i,
  input  logic      val_w_i,
  input  w_ctrl_t   w_i,
  output logic      load_use_o,
  output byp_sel_e  op1_byp_o,
  output byp_sel_e  op2_byp_o
);

  // older stage will write the register we read
  function automatic logic hit(input logic v, input logic wen, input reg_addr_t wa,
                               input reg_addr_t rs);
    return v && wen && (wa != '0) && (wa == rs);
  endfunction

  // youngest producer wins
  function automatic byp_sel_e pick(input logic x, input logic m, input logic w);
    if (x)
      return BYP_X;
    else if (m)
      return BYP_M;
    else if (w)
      return BYP_W;
    return BYP_RF;
  endfunction

  logic src1, src2;
  logic x1, m1, w1;
  logic x2, m2, w2;
  logic x_load;
  logic lu1, lu2;

  assign src1 = val_d_i && dec_i.rs1_en;
  assign src2 = val_d_i && dec_i.rs2_en;

  assign x1 = src1 && hit(val_x_i, x_i.rf_wen, x_i.rf_waddr, dec_i.rs1);
  assign m1 = src1 && hit(val_m_i, m_i.rf_wen, m_i.rf_waddr, dec_i.rs1);
  assign w1 = src1 && hit(val_w_i, w_i.rf_wen, w_i.rf_waddr, dec_i.rs1);
  assign x2 = src2 && hit(val_x_i, x_i.rf_wen, x_i.rf_waddr, dec_i.rs2);
  assign m2 = src2 && hit(val_m_i, m_i.rf_wen, m_i.rf_waddr, dec_i.rs2);
  assign w2 = src2 && hit(val_w_i, w_i.rf_wen, w_i.rf_waddr, dec_i.rs2);

  // load data only exists after M
  assign x_load     = x_i.dmem_type == DMEM_LOAD;
  assign lu1        = x1 && x_load;
  assign lu2        = x2 && x_load;
  assign load_use_o = lu1 || lu2;

  assign op1_byp_o = pick(x1 && !x_load, m1, w1);
  assign op2_byp_o = pick(x2 && !x_load, m2, w2);

  // a stall needs a live load in X, and then no operand takes the X path
  a_lu_no_xbyp: assert property (@(posedge clk)
    load_use_o |-> val_x_i && (x_i.dmem_type == DMEM_LOAD) &&
                   (op1_byp_o != BYP_X) && (op2_byp_o != BYP_X));

endmodule

//--- inst_decoder.sv
/* rv32i subset decoder, purely combinational
   unsupported encodings return an all-zero struct with inst_val low */
`timescale 1ns/1ps

module inst_decoder import proc_ctrl_pkg::*; (
  input  logic [INST_W-1:0] inst_i,
  output dec_ctrl_t         dec_o
);

  logic [6:0] opcode;
  logic [2:0] f3;
  logic [6:0] f7;
  logic       fn_alt;
  alu_fn_e    fn;
  logic       shift_ok;
  br_type_e   b_type;
  logic       b_ok;
  dec_ctrl_t  d;

  assign opcode = inst_i[6:0];
  assign f3     = inst_i[14:12];
  assign f7     = inst_i[31:25];

  // one row of the control table
  function automatic dec_ctrl_t cs(
    input logic       val,
    input br_type_e   br,
    input imm_type_e  imm,
    input logic       r1_en,
    input logic       r2_en,
    input op1_sel_e   op1,
    input op2_sel_e   op2,
    input alu_fn_e    alu,
    input ex_res_e    ex,
    input dmem_type_e dm,
    input wb_sel_e    wb,
    input logic       wen
  );
    dec_ctrl_t c;
    c           = '0;
    c.inst_val  = val;
    c.br_type   = br;
    c.imm_type  = imm;
    c.rs1_en    = r1_en;
    c.rs2_en    = r2_en;
    c.op1_sel   = op1;
    c.op2_sel   = op2;
    c.alu_fn    = alu;
    c.ex_res    = ex;
    c.dmem_type = dm;
    c.wb_sel    = wb;
    c.rf_wen    = wen;
    return c;
  endfunction

  // ------------------------------
  // alu function from funct3/funct7
  // ------------------------------
  // alt form only exists for sub, sra, srai
  assign fn_alt = (f7 == F7_ALT) && ((opcode == OPC_OP && f3 == 3'b000) || f3 == 3'b101);
  // R-type and shifts need a legal funct7
  assign shift_ok = (f7 == F7_BASE) || fn_alt;

  always_comb begin
    case (f3)
      3'b000:  fn = fn_alt ? ALU_SUB : ALU_ADD;
      3'b001:  fn = ALU_SLL;
      3'b010:  fn = ALU_SLT;
      3'b011:  fn = ALU_SLTU;
      3'b100:  fn = ALU_XOR;
      3'b101:  fn = fn_alt ? ALU_SRA : ALU_SRL;
      3'b110:  fn = ALU_OR;
      default: fn = ALU_AND;
    endcase
  end

  // branch flavour, 010/011 are reserved
  always_comb begin
    b_ok = Y;
    case (f3)
      3'b000:  b_type = BR_BEQ;
      3'b001:  b_type = BR_BNE;
      3'b100:  b_type = BR_BLT;
      3'b101:  b_type = BR_BGE;
      3'b110:  b_type = BR_BLTU;
      3'b111:  b_type = BR_BGEU;
      default: begin
        b_type = BR_NA;
        b_ok   = N;
      end
    endcase
  end

  // ------------------------------
  // control table
  // ------------------------------
  always_comb begin
    d = cs(N, BR_NA, IMM_I, N, N, OP1_RF, OP2_RF, ALU_ADD, EX_PC4, DMEM_NONE, WB_ALU, N);
    //                val       br       imm    r1 r2 op1     op2      alu       ex
    case (opcode)
      OPC_OP:     d = cs(shift_ok, BR_NA, IMM_I, Y, Y, OP1_RF, OP2_RF, fn, EX_ALU,
                         DMEM_NONE, WB_ALU, Y);
      OPC_OP_IMM: d = cs(f3 != 3'b001 && f3 != 3'b101 || shift_ok, BR_NA, IMM_I, Y, N,
                         OP1_RF, OP2_IMM, fn, EX_ALU, DMEM_NONE, WB_ALU, Y);
      OPC_LUI:    d = cs(Y, BR_NA, IMM_U, N, N, OP1_RF, OP2_IMM, ALU_CP1, EX_ALU,
                         DMEM_NONE, WB_ALU, Y);
      OPC_AUIPC:  d = cs(Y, BR_NA, IMM_U, N, N, OP1_PC, OP2_IMM, ALU_ADD, EX_ALU,
                         DMEM_NONE, WB_ALU, Y);
      // only word access is supported
      OPC_LOAD:   d = cs(f3 == 3'b010, BR_NA, IMM_I, Y, N, OP1_RF, OP2_IMM, ALU_ADD, EX_ALU,
                         DMEM_LOAD, WB_MEM, Y);
      OPC_STORE:  d = cs(f3 == 3'b010, BR_NA, IMM_S, Y, Y, OP1_RF, OP2_IMM, ALU_ADD, EX_ALU,
                         DMEM_STORE, WB_ALU, N);
      // jumps write the link address pc+4
      OPC_JAL:    d = cs(Y, BR_JAL, IMM_J, N, N, OP1_PC, OP2_IMM, ALU_ADD, EX_PC4,
                         DMEM_NONE, WB_ALU, Y);
      OPC_JALR:   d = cs(f3 == 3'b000, BR_JALR, IMM_I, Y, N, OP1_RF, OP2_IMM, ALU_JALR,
                         EX_PC4, DMEM_NONE, WB_ALU, Y);
      OPC_BRANCH: d = cs(b_ok, b_type, IMM_B, Y, Y, OP1_RF, OP2_RF, ALU_ADD, EX_ALU,
                         DMEM_NONE, WB_ALU, N);
      default:    d.inst_val = N;
    endcase
    // register fields only for legal encodings
    if (d.inst_val) begin
      d.rs1      = inst_i[19:15];
      d.rs2      = inst_i[24:20];
      d.rf_waddr = inst_i[11:7];
    end else begin
      d = '0;
    end
    dec_o = d;
    if (dec_o.dmem_type == DMEM_STORE) begin
      assert (!dec_o.rf_wen) else $error("store decoded with register write");
    end
  end

endmodule

//--- proc_ctrl.sv
/* five-stage control: stall/squash chain, F/D state, memory stream handshakes
   W never stalls; a transfer needs val and rdy high in the same cycle */
`timescale 1ns/1ps

module proc_ctrl import proc_ctrl_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic [INST_W-1:0] inst_d_i,
  input  br_cond_t          br_cond_x_i,
  output logic              imem_req_val_o,
  input  logic              imem_req_rdy_i,
  input  logic              imem_resp_val_i,
  output logic              imem_resp_rdy_o,
  output logic              imem_resp_drop_o,
  output logic              dmem_req_val_o,
  input  logic              dmem_req_rdy_i,
  input  logic              dmem_resp_val_i,
  output logic              dmem_resp_rdy_o,
  output dpath_ctrl_t       ctrl_o,
  output logic              commit_o
);

  logic val_f, val_d, val_x, val_m, val_w;
  logic next_val_f, next_val_d, next_val_x, next_val_m;
  logic ostall_f, ostall_d, ostall_x, ostall_m;
  logic stall_f, stall_d, stall_x, stall_m;
  logic osquash_d, osquash_x;
  logic squash_f, squash_d;
  logic reg_en_f, reg_en_d, reg_en_x, reg_en_m;
  logic load_use, redirect_d, redirect_x;
  byp_sel_e  op1_byp, op2_byp;
  pc_sel_e   pc_sel_f;
  dec_ctrl_t dec_d;
  x_ctrl_t   x_next, x_q;
  m_ctrl_t   m_next, m_q;
  w_ctrl_t   w_next, w_q;

  inst_decoder u_dec (.inst_i(inst_d_i), .dec_o(dec_d));

  hazard_unit u_haz (
    .clk(clk), .dec_i(dec_d), .val_d_i(val_d),
    .val_x_i(val_x), .x_i(x_q), .val_m_i(val_m), .m_i(m_q),
    .val_w_i(val_w), .w_i(w_q),
    .load_use_o(load_use), .op1_byp_o(op1_byp), .op2_byp_o(op2_byp)
  );

  branch_resolve u_br (
    .val_d_i(val_d), .br_d_i(dec_d.br_type), .val_x_i(val_x), .br_x_i(x_q.br_type),
    .cond_i(br_cond_x_i), .redirect_d_o(redirect_d), .redirect_x_o(redirect_x),
    .pc_sel_o(pc_sel_f)
  );

  // ------------------------------
  // stall and squash chain
  // ------------------------------
  assign ostall_f = val_f && !imem_resp_val_i;
  assign ostall_d = val_d && load_use;
  assign ostall_x = val_x && (x_q.dmem_type != DMEM_NONE) && !dmem_req_rdy_i;
  assign ostall_m = val_m && (m_q.dmem_type != DMEM_NONE) && !dmem_resp_val_i;

  // a stage stalls on its own or on any later stage
  assign stall_m = val_m && ostall_m;
  assign stall_x = val_x && (ostall_x || ostall_m);
  assign stall_d = val_d && (ostall_d || ostall_x || ostall_m);
  assign stall_f = val_f && (ostall_f || ostall_d || ostall_x || ostall_m);

  // stalled stage must not redirect, else the squash fires twice
  assign osquash_d = val_d && !stall_d && redirect_d;
  assign osquash_x = val_x && !stall_x && redirect_x;
  assign squash_f  = val_f && (osquash_d || osquash_x);
  assign squash_d  = val_d && osquash_x;

  assign reg_en_f = !stall_f || squash_f;
  assign reg_en_d = !stall_d || squash_d;
  assign reg_en_x = !stall_x;
  assign reg_en_m = !stall_m;

  // ------------------------------
  // F and D state
  // ------------------------------
  always_ff @(posedge clk) begin
    if (reset)
      val_f <= 1'b0;
    else if (reg_en_f)
      val_f <= 1'b1;
  end

  always_ff @(posedge clk) begin
    if (reset)
      val_d <= 1'b0;
    else if (reg_en_d)
      val_d <= next_val_f;
  end

  assign next_val_f = val_f && !stall_f && !squash_f;
  // illegal encodings die in D
  assign next_val_d = val_d && !stall_d && !squash_d && dec_d.inst_val;
  assign next_val_x = val_x && !stall_x;
  assign next_val_m = val_m && !stall_m;

  // fetch request goes out ahead of F
  assign imem_req_val_o   = reg_en_f && !reset;
  assign imem_resp_rdy_o  = reg_en_f;
  assign imem_resp_drop_o = squash_f;

  // ------------------------------
  // X, M, W registers
  // ------------------------------
  always_comb begin
    x_next.br_type   = dec_d.br_type;
    x_next.alu_fn    = dec_d.alu_fn;
    x_next.ex_res    = dec_d.ex_res;
    x_next.dmem_type = dec_d.dmem_type;
    x_next.wb_sel    = dec_d.wb_sel;
    x_next.rf_wen    = dec_d.rf_wen;
    x_next.rf_waddr  = dec_d.rf_waddr;
    m_next.dmem_type = x_q.dmem_type;
    m_next.wb_sel    = x_q.wb_sel;
    m_next.rf_wen    = x_q.rf_wen;
    m_next.rf_waddr  = x_q.rf_waddr;
    w_next.rf_wen    = m_q.rf_wen;
    w_next.rf_waddr  = m_q.rf_waddr;
  end

  ctrl_stage_reg #(.payload_t(x_ctrl_t)) u_x_reg (
    .clk(clk), .reset(reset), .en_i(reg_en_x), .val_i(next_val_d), .pay_i(x_next),
    .val_o(val_x), .pay_o(x_q)
  );

  ctrl_stage_reg #(.payload_t(m_ctrl_t)) u_m_reg (
    .clk(clk), .reset(reset), .en_i(reg_en_m), .val_i(next_val_x), .pay_i(m_next),
    .val_o(val_m), .pay_o(m_q)
  );

  // W is always enabled
  ctrl_stage_reg #(.payload_t(w_ctrl_t)) u_w_reg (
    .clk(clk), .reset(reset), .en_i(1'b1), .val_i(next_val_m), .pay_i(w_next),
    .val_o(val_w), .pay_o(w_q)
  );

  // data memory handshakes, only when not stalling
  assign dmem_req_val_o  = val_x && !stall_x && (x_q.dmem_type != DMEM_NONE);
  assign dmem_resp_rdy_o = val_m && !stall_m && (m_q.dmem_type != DMEM_NONE);
  assign commit_o        = val_w;

  // datapath control bundle
  always_comb begin
    ctrl_o.reg_en_F    = reg_en_f;
    ctrl_o.reg_en_D    = reg_en_d;
    ctrl_o.reg_en_X    = reg_en_x;
    ctrl_o.reg_en_M    = reg_en_m;
    ctrl_o.reg_en_W    = 1'b1;
    ctrl_o.pc_sel_F    = pc_sel_f;
    ctrl_o.op1_sel_D   = dec_d.op1_sel;
    ctrl_o.op2_sel_D   = dec_d.op2_sel;
    ctrl_o.imm_type_D  = dec_d.imm_type;
    ctrl_o.op1_byp_D   = op1_byp;
    ctrl_o.op2_byp_D   = op2_byp;
    ctrl_o.alu_fn_X    = x_q.alu_fn;
    ctrl_o.ex_res_X    = x_q.ex_res;
    ctrl_o.dmem_type_X = x_q.dmem_type;
    ctrl_o.wb_sel_M    = m_q.wb_sel;
    ctrl_o.rf_wen_W    = val_w && w_q.rf_wen;
    ctrl_o.rf_waddr_W  = w_q.rf_waddr;
  end

  // a request leaves a live memory op in X and shows up in M one cycle later
  a_dmem_needs_x: assert property (@(posedge clk) disable iff (reset)
    dmem_req_val_o |=> val_m && (m_q.dmem_type != DMEM_NONE));

endmodule

//--- proc_ctrl_pkg.sv
/* shared types for the five-stage pipeline control unit
   dec_ctrl_t also carries rs1/rs2 so the hazard unit can compare specifiers */
package proc_ctrl_pkg;

  // widths
  localparam int INST_W     = 32;
  localparam int REG_ADDR_W = 5;

  // shorthand for the decode table
  localparam logic Y = 1'b1;
  localparam logic N = 1'b0;

  // ------------------------------
  // rv32i encodings
  // ------------------------------
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

  // funct7 for sub / sra / srai
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // ------------------------------
  // control encodings
  // ------------------------------
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT,
    ALU_SLTU, ALU_SRA, ALU_SRL, ALU_SLL, ALU_JALR, ALU_CP1
  } alu_fn_e;

  typedef enum logic [3:0] {
    BR_NA, BR_BNE, BR_JAL, BR_JALR, BR_BEQ, BR_BLT, BR_BLTU, BR_BGE, BR_BGEU
  } br_type_e;

  typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_type_e;
  typedef enum logic       {OP1_RF, OP1_PC} op1_sel_e;
  typedef enum logic [1:0] {OP2_RF, OP2_IMM} op2_sel_e;
  typedef enum logic [1:0] {EX_PC4, EX_ALU} ex_res_e;
  typedef enum logic [1:0] {DMEM_NONE, DMEM_LOAD, DMEM_STORE} dmem_type_e;
  typedef enum logic       {WB_ALU, WB_MEM} wb_sel_e;
  typedef enum logic [1:0] {PC_PLUS4, PC_BRANCH, PC_JAL, PC_JALR} pc_sel_e;
  typedef enum logic [1:0] {BYP_RF, BYP_X, BYP_M, BYP_W} byp_sel_e;

  // compare results from the datapath in X
  typedef struct packed {
    logic eq;
    logic lt;
    logic ltu;
  } br_cond_t;

  // full decode of the D instruction
  typedef struct packed {
    logic       inst_val;
    br_type_e   br_type;
    imm_type_e  imm_type;
    logic       rs1_en;
    logic       rs2_en;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    op1_sel_e   op1_sel;
    op2_sel_e   op2_sel;
    alu_fn_e    alu_fn;
    ex_res_e    ex_res;
    dmem_type_e dmem_type;
    wb_sel_e    wb_sel;
    logic       rf_wen;
    reg_addr_t  rf_waddr;
  } dec_ctrl_t;

  // stage payloads shrink as fields are consumed
  typedef struct packed {
    br_type_e   br_type;
    alu_fn_e    alu_fn;
    ex_res_e    ex_res;
    dmem_type_e dmem_type;
    wb_sel_e    wb_sel;
    logic       rf_wen;
    reg_addr_t  rf_waddr;
  } x_ctrl_t;

  typedef struct packed {
    dmem_type_e dmem_type;
    wb_sel_e    wb_sel;
    logic       rf_wen;
    reg_addr_t  rf_waddr;
  } m_ctrl_t;

  typedef struct packed {
    logic      rf_wen;
    reg_addr_t rf_waddr;
  } w_ctrl_t;

  // everything the datapath needs from control
  typedef struct packed {
    logic       reg_en_F;
    logic       reg_en_D;
    logic       reg_en_X;
    logic       reg_en_M;
    logic       reg_en_W;
    pc_sel_e    pc_sel_F;
    op1_sel_e   op1_sel_D;
    op2_sel_e   op2_sel_D;
    imm_type_e  imm_type_D;
    byp_sel_e   op1_byp_D;
    byp_sel_e   op2_byp_D;
    alu_fn_e    alu_fn_X;
    ex_res_e    ex_res_X;
    dmem_type_e dmem_type_X;
    wb_sel_e    wb_sel_M;
    logic       rf_wen_W;
    reg_addr_t  rf_waddr_W;
  } dpath_ctrl_t;

endpackage

//--- run.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_proc_ctrl -f tb.f -o tb_sim \
  > build.log 2>&1 &&
./obj_dir/tb_sim > sim.log 2>&1 ||
{ echo "build or simulation error, see build.log and sim.log"; exit 1; }
grep -q "TESTS PASSED" sim.log && echo "simulation passed" ||
{ echo "simulation failed, see sim.log"; exit 1; }

//--- tb.f
proc_ctrl_pkg.sv
inst_decoder.sv
hazard_unit.sv
branch_resolve.sv
ctrl_stage_reg.sv
proc_ctrl.sv
tb_proc_ctrl.sv

//--- tb_proc_ctrl.sv
/* testbench for proc_ctrl, one table row per clock cycle after reset
   the table stands for the instruction in D, so D is only valid from row 2 */
`timescale 1ns/1ps

module tb_proc_ctrl import proc_ctrl_pkg::*; ();

  localparam int RESET_CYCLES = 10;
  localparam int SLACK_CYCLES = 50;
  // addi x0, x0, 0
  localparam logic [31:0] NOP = 32'h0000_0013;

  // stimulus and expected outputs for one cycle
  typedef struct packed {
    logic [2:0]  test;
    logic [31:0] inst;
    br_cond_t    cond;
    logic [3:0]  strm;
    logic        en_d;
    logic        dreq;
    logic        ireq;
    logic        cmt;
    logic        wen;
    byp_sel_e    b1;
    byp_sel_e    b2;
    pc_sel_e     pcs;
    reg_addr_t   wa;
  } row_t;

  logic              clk;
  logic              reset;
  logic [INST_W-1:0] inst_d_i;
  br_cond_t          br_cond_x_i;
  logic              imem_req_val, imem_req_rdy, imem_resp_val, imem_resp_rdy;
  logic              imem_resp_drop, dmem_req_val, dmem_req_rdy, dmem_resp_val;
  logic              dmem_resp_rdy, commit;
  dpath_ctrl_t       ctrl;

  row_t       rows[$];
  logic [2:0] build_test;
  int         checks, errors, test_errs, cycles;
  string      test_name [6] = '{"decode and writeback", "bypass", "load-use",
                                "taken branch", "jumps", "back-pressure"};

  proc_ctrl UUT (
    .clk(clk), .reset(reset), .inst_d_i(inst_d_i), .br_cond_x_i(br_cond_x_i),
    .imem_req_val_o(imem_req_val), .imem_req_rdy_i(imem_req_rdy),
    .imem_resp_val_i(imem_resp_val), .imem_resp_rdy_o(imem_resp_rdy),
    .imem_resp_drop_o(imem_resp_drop), .dmem_req_val_o(dmem_req_val),
    .dmem_req_rdy_i(dmem_req_rdy), .dmem_resp_val_i(dmem_resp_val),
    .dmem_resp_rdy_o(dmem_resp_rdy), .ctrl_o(ctrl), .commit_o(commit)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // rv32i word, f7 and upper immediate bits left at zero
  function automatic logic [31:0] enc(input logic [6:0] opc, input logic [2:0] f3,
                                      input reg_addr_t rd, input reg_addr_t rs1,
                                      input reg_addr_t rs2);
    return {7'b0, rs2, rs1, f3, rd, opc};
  endfunction

  // flags are {reg_en_D, dmem_req_val, imem_req_val, commit, rf_wen_W}
  task automatic add_row(input logic [31:0] inst, input br_cond_t cond,
                         input logic [3:0] strm, input logic [4:0] flags,
                         input byp_sel_e b1, input byp_sel_e b2, input pc_sel_e pcs,
                         input reg_addr_t wa);
    row_t r;
    r.test = build_test;
    r.inst = inst;
    r.cond = cond;
    r.strm = strm;
    {r.en_d, r.dreq, r.ireq, r.cmt, r.wen} = flags;
    r.b1   = b1;
    r.b2   = b2;
    r.pcs  = pcs;
    r.wa   = wa;
    rows.push_back(r);
  endtask

  task automatic compare_value(input string sig, input int row, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("ERR row %0d %s got %h exp %h", row, sig, got, exp);
      errors++;
      test_errs++;
    end
  endtask

  // ------------------------------
  // stimulus table
  // ------------------------------
  task automatic build_table();
    // x1..x4 written, SW stores x3 at base x4
    build_test = 3'd0;
    add_row(NOP, 3'b000, 4'hf, 5'b10100, BYP_RF, BYP_RF, PC_PLUS4, 0);
    add_row(NOP, 3'b000, 4'hf, 5'b10100, BYP_RF, BYP_RF, PC_PLUS4, 0);
    add_row(enc(OPC_OP, 0, 1, 2, 3), 3'b000, 4'hf, 5'b10100, BYP_RF, BYP_RF, PC_PLUS4, 0);
    add_row(enc(OPC_OP_IMM, 0, 2, 1, 0), 3'b000, 4'hf, 5'b10100, BYP_X, BYP_RF, PC_PLUS4, 0);
    add_row(enc(OPC_LUI, 0, 3, 0, 0), 3'b000, 4'hf, 5'b10100, BYP_RF, BYP_RF, PC_PLUS4, 0);
    build_test = 3'd1;
    add_row(enc(OPC_OP, 0, 4, 1, 2), 3'b000, 4'hf, 5'b10111, BYP_W, BYP_M, PC_PLUS4, 1);
    add_row(enc(OPC_STORE, 2, 0, 4, 3), 3'b000, 4'hf, 5'b10111, BYP_X, BYP_M, PC_PLUS4, 2);
    // write to x0 never bypasses
    add_row(enc(OPC_OP_IMM, 0, 0, 1, 0), 3'b000, 4'hf, 5'b11111, BYP_RF, BYP_RF, PC_PLUS4, 3);
    add_row(enc(OPC_OP, 0, 5, 0, 4), 3'b000, 4'hf, 5'b10111, BYP_RF, BYP_W, PC_PLUS4, 4);
    build_test = 3'd2;
    add_row(enc(OPC_LOAD, 2, 6, 5, 0), 3'b000, 4'hf, 5'b10110, BYP_X, BYP_RF, PC_PLUS4, 0);
    add_row(enc(OPC_OP, 0, 7, 6, 1), 3'b000, 4'hf, 5'b01011, BYP_RF, BYP_RF, PC_PLUS4, 0);
    add_row(enc(OPC_OP, 0, 7, 6, 1), 3'b000, 4'hf, 5'b10111, BYP_M, BYP_RF, PC_PLUS4, 5);
    // beq taken in the next row, then bne with eq high
    build_test = 3'd3;
    add_row(enc(OPC_BRANCH, 0, 0, 7, 6), 3'b000, 4'hf, 5'b10111, BYP_X, BYP_W, PC_PLUS4, 6);
    add_row(enc(OPC_OP_IMM, 0, 8, 0, 0), 3'b100, 4'hf, 5'b10100, BYP_RF, BYP_RF, PC_BRANCH, 0);
    add_row(enc(OPC_OP_IMM, 0, 9, 0, 0), 3'b000, 4'hf, 5'b10111, BYP_RF, BYP_RF, PC_PLUS4, 7);
    add_row(enc(OPC_BRANCH, 1, 0, 1, 2), 3'b000, 4'hf, 5'b10110, BYP_RF, BYP_RF, PC_PLUS4, 0);
    build_test = 3'd4;
    add_row(enc(OPC_JAL, 0, 1, 0, 0), 3'b100, 4'hf, 5'b10100, BYP_RF, BYP_RF, PC_JAL, 0);
    add_row(NOP, 3'b000, 4'hf, 5'b10100, BYP_RF, BYP_RF, PC_PLUS4, 0);
    add_row(enc(OPC_JALR, 0, 2, 1, 0), 3'b000, 4'hf, 5'b10110, BYP_M, BYP_RF, PC_PLUS4, 0);
    add_row(enc(OPC_OP_IMM, 0, 11, 2, 0), 3'b000, 4'hf, 5'b10111, BYP_X, BYP_RF, PC_JALR, 1);
    add_row(NOP, 3'b000, 4'hf, 5'b10100, BYP_RF, BYP_RF, PC_PLUS4, 0);
    // lw held in X by dmem_req_rdy low for three rows
    build_test = 3'd5;
    add_row(enc(OPC_LOAD, 2, 12, 0, 0), 3'b000, 4'hf, 5'b10111, BYP_RF, BYP_RF, PC_PLUS4, 2);
    add_row(enc(OPC_OP, 0, 13, 1, 0), 3'b000, 4'hd, 5'b00000, BYP_RF, BYP_RF, PC_PLUS4, 0);
    add_row(enc(OPC_OP, 0, 13, 1, 0), 3'b000, 4'hd, 5'b00000, BYP_RF, BYP_RF, PC_PLUS4, 0);
    add_row(enc(OPC_OP, 0, 13, 1, 0), 3'b000, 4'hd, 5'b00000, BYP_RF, BYP_RF, PC_PLUS4, 0);
    add_row(enc(OPC_OP, 0, 13, 1, 0), 3'b000, 4'hf, 5'b11100, BYP_RF, BYP_RF, PC_PLUS4, 0);
    add_row(enc(OPC_OP, 0, 14, 12, 13), 3'b000, 4'hf, 5'b10100, BYP_M, BYP_X, PC_PLUS4, 0);
    add_row(NOP, 3'b000, 4'hf, 5'b10111, BYP_RF, BYP_RF, PC_PLUS4, 12);
    add_row(NOP, 3'b000, 4'hf, 5'b10111, BYP_RF, BYP_RF, PC_PLUS4, 13);
    add_row(NOP, 3'b000, 4'hf, 5'b10111, BYP_RF, BYP_RF, PC_PLUS4, 14);
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    row_t r;
    logic prev_dreq;
    reset         = 1'b1;
    inst_d_i      = NOP;
    br_cond_x_i   = '0;
    imem_req_rdy  = 1'b1;
    imem_resp_val = 1'b1;
    dmem_req_rdy  = 1'b1;
    dmem_resp_val = 1'b1;
    prev_dreq     = 1'b0;
    build_table();
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset = 1'b0;
    for (int i = 0; i < rows.size(); i++) begin
      if (i > 0) begin
        @(posedge clk);
        #1;
      end
      r           = rows[i];
      inst_d_i    = r.inst;
      br_cond_x_i = r.cond;
      {imem_req_rdy, imem_resp_val, dmem_req_rdy, dmem_resp_val} = r.strm;
      // sample just before the next edge
      #2;
      compare_value("reg_en_D", i, 32'(ctrl.reg_en_D), 32'(r.en_d));
      compare_value("op1_byp_D", i, 32'(ctrl.op1_byp_D), 32'(r.b1));
      compare_value("op2_byp_D", i, 32'(ctrl.op2_byp_D), 32'(r.b2));
      compare_value("pc_sel_F", i, 32'(ctrl.pc_sel_F), 32'(r.pcs));
      // any redirect squashes F
      compare_value("imem_resp_drop", i, 32'(imem_resp_drop), 32'(r.pcs != PC_PLUS4));
      compare_value("dmem_req_val", i, 32'(dmem_req_val), 32'(r.dreq));
      compare_value("imem_req_val", i, 32'(imem_req_val), 32'(r.ireq));
      // F takes a response whenever it may advance
      compare_value("imem_resp_rdy", i, 32'(imem_resp_rdy), 32'(r.ireq));
      // request accepted last cycle now sits in M
      compare_value("dmem_resp_rdy", i, 32'(dmem_resp_rdy), 32'(prev_dreq && r.strm[0]));
      compare_value("commit", i, 32'(commit), 32'(r.cmt));
      compare_value("rf_wen_W", i, 32'(ctrl.rf_wen_W), 32'(r.wen));
      if (r.wen)
        compare_value("rf_waddr_W", i, 32'(ctrl.rf_waddr_W), 32'(r.wa));
      if (i == rows.size() - 1 || rows[i+1].test != r.test) begin
        $display("test %0d %s: %0d mismatches", r.test + 1, test_name[r.test], test_errs);
        test_errs = 0;
      end
      prev_dreq = r.dreq;
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

  // run limit from table length
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > rows.size() + RESET_CYCLES + SLACK_CYCLES) begin
      $display("timeout after %0d cycles, table did not finish", cycles);
      $display("TESTS FAILED");
      $finish;
    end
  end

endmodule
